// File: rvfi_trace_pkg.sv
// Retirement trace types: trap, interrupt, retired record, annotated record and cause constants

package rvfi_trace_pkg;

  // Field widths of the retirement trace
  localparam int unsigned EXC_CAUSE_W  = 6;
  localparam int unsigned DBG_CAUSE_W  = 3;
  localparam int unsigned INTR_CAUSE_W = 11;

  // Position of the cause field inside dcsr
  localparam int unsigned DCSR_CAUSE_LSB = 6;

  // NMI causes, legal for both interrupt controllers
  localparam logic [INTR_CAUSE_W-1:0] NMI_CAUSE_LO = 11'd1024;
  localparam logic [INTR_CAUSE_W-1:0] NMI_CAUSE_HI = 11'd1027;

  // Trap information of one retired instruction
  typedef struct packed {
    logic                   exception;
    logic [EXC_CAUSE_W-1:0] exception_cause;
    logic                   debug;
    logic [DBG_CAUSE_W-1:0] debug_cause;
  } trap_t;

  // Interrupt taken before this instruction
  typedef struct packed {
    logic                    interrupt;
    logic [INTR_CAUSE_W-1:0] cause;
  } intr_t;

  // One retired instruction, RVFI style
  typedef struct packed {
    logic [4:0]             rs1_addr;
    logic [4:0]             rs2_addr;
    logic [31:0]            rs1_rdata;
    logic [31:0]            rs2_rdata;
    logic [DBG_CAUSE_W-1:0] dbg;
    logic [31:0]            dcsr_rdata;
    trap_t                  trap;
    intr_t                  intr;
    logic [31:0]            mcause_wdata;
    logic [31:0]            mcause_wmask;
    logic                   dbg_mode;
  } retire_t;

  // Record plus the history that the checks need
  typedef struct packed {
    retire_t rec;
    // Debug mode of the previous accepted record
    logic    was_dbg_mode;
    // First record accepted after reset
    logic    first_retire;
  } annot_t;

endpackage

// File: trace_check_pkg.sv
// Checker result types: violation mask, report record and failure count width

package trace_check_pkg;

  // Width of the saturating failure count
  localparam int unsigned CNT_W = 16;

  // One flag per rule, set when the rule is broken
  typedef struct packed {
    // rs1 read data nonzero on the first retirement
    logic rs1_reset;
    // rs2 read data nonzero on the first retirement
    logic rs2_reset;
    // Debug entry cause differs from dcsr.cause
    logic dbg_cause;
    // Exception cause differs from masked mcause
    logic exc_mismatch;
    // Interrupt cause outside the legal set
    logic intr_illegal;
    logic exc_no_cause;
    logic dbg_no_cause;
  } violation_t;

  // Report sent out for every record
  typedef struct packed {
    violation_t       viol;
    logic             any_fail;
    // Failing records so far, including this one
    logic [CNT_W-1:0] fail_count;
  } report_t;

endpackage

// File: trace_pipe_reg.sv
// One-entry valid/ready pipeline register with a type parameter for the payload

`timescale 1ns/100ps
`default_nettype none

module trace_pipe_reg #(
  parameter type T = logic
) (
  input  logic clk_i,
  input  logic rst_ni,

  input  logic in_valid,
  input  T     in_data,
  output logic in_ready,

  output logic out_valid,
  output T     out_data,
  input  logic out_ready
);

  logic full_q;
  T     data_q;
  logic in_xfer;
  logic out_xfer;

  // Accept when empty or when the held entry leaves this cycle
  assign in_ready = !full_q || out_ready;
  assign in_xfer  = in_valid && in_ready;
  assign out_xfer = full_q && out_ready;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      full_q <= 1'b0;
    end else if (in_xfer) begin
      full_q <= 1'b1;
    end else if (out_xfer) begin
      full_q <= 1'b0;
    end
  end

  // Payload only
  always_ff @(posedge clk_i) begin
    if (in_xfer) begin
      data_q <= in_data;
    end
  end

  assign out_valid = full_q;
  assign out_data  = data_q;

endmodule

`default_nettype wire

// File: trace_mode_tracker.sv
// Stage 1 of the trace checker: previous debug mode and first-after-reset annotation

`timescale 1ns/100ps
`default_nettype none

module trace_mode_tracker (
  input  logic                  clk_i,
  input  logic                  rst_ni,

  input  logic                  in_valid,
  input  rvfi_trace_pkg::retire_t in_rec,
  output logic                  in_ready,

  output logic                  out_valid,
  output rvfi_trace_pkg::annot_t  out_annot,
  input  logic                  out_ready
);

  logic                   was_dbg_mode_q;
  logic                   first_retire_q;
  logic                   in_xfer;
  rvfi_trace_pkg::annot_t annot_d;

  assign in_xfer = in_valid && in_ready;

  // History moves on when a record enters, not when it leaves
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      was_dbg_mode_q <= 1'b0;
      first_retire_q <= 1'b1;
    end else if (in_xfer) begin
      was_dbg_mode_q <= in_rec.dbg_mode;
      first_retire_q <= 1'b0;
    end
  end

  always_comb begin
    annot_d              = '0;
    annot_d.rec          = in_rec;
    annot_d.was_dbg_mode = was_dbg_mode_q;
    annot_d.first_retire = first_retire_q;
  end

  trace_pipe_reg #(
    .T (rvfi_trace_pkg::annot_t)
  ) u_pipe_reg (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .in_valid  (in_valid),
    .in_data   (annot_d),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_data  (out_annot),
    .out_ready (out_ready)
  );

endmodule

`default_nettype wire

// File: trace_cause_checker.sv
// Stage 2 of the trace checker: reset value, cause and legality rules into a violation mask

`timescale 1ns/100ps
`default_nettype none

module trace_cause_checker #(
  parameter logic CLIC          = 1'b0,
  parameter int   CLIC_ID_WIDTH = 5
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,

  input  logic                        in_valid,
  input  rvfi_trace_pkg::annot_t      in_annot,
  output logic                        in_ready,

  output logic                        out_valid,
  output trace_check_pkg::violation_t out_viol,
  input  logic                        out_ready
);

  rvfi_trace_pkg::retire_t rec;

  logic [rvfi_trace_pkg::DBG_CAUSE_W-1:0]  dcsr_cause;
  logic [rvfi_trace_pkg::INTR_CAUSE_W-1:0] mcause_exccode;
  logic [rvfi_trace_pkg::INTR_CAUSE_W-1:0] exc_cause_ext;
  logic                                    nmi_cause;
  logic                                    cause_legal;
  trace_check_pkg::violation_t             viol_d;

  assign rec = in_annot.rec;

  assign dcsr_cause =
    rec.dcsr_rdata[rvfi_trace_pkg::DCSR_CAUSE_LSB +: rvfi_trace_pkg::DBG_CAUSE_W];

  // Exception code part of the mcause write
  assign mcause_exccode =
    rec.mcause_wdata[rvfi_trace_pkg::INTR_CAUSE_W-1:0] &
    rec.mcause_wmask[rvfi_trace_pkg::INTR_CAUSE_W-1:0];

  assign exc_cause_ext = {
    {(rvfi_trace_pkg::INTR_CAUSE_W - rvfi_trace_pkg::EXC_CAUSE_W){1'b0}},
    rec.trap.exception_cause
  };

  assign nmi_cause = (rec.intr.cause >= rvfi_trace_pkg::NMI_CAUSE_LO) &&
                     (rec.intr.cause <= rvfi_trace_pkg::NMI_CAUSE_HI);

  // Legal interrupt causes depend on the controller
  if (CLIC) begin : gen_legal_clic
    localparam logic [31:0] MAX_CLIC_ID = 32'(2**CLIC_ID_WIDTH - 1);

    assign cause_legal = ({21'd0, rec.intr.cause} <= MAX_CLIC_ID) || nmi_cause;
  end else begin : gen_legal_basic
    assign cause_legal = (rec.intr.cause inside {11'd3, 11'd7, 11'd11, [11'd16:11'd31]}) ||
                         nmi_cause;
  end

  always_comb begin
    viol_d = '0;

    // Register file reads right after reset must see zero
    viol_d.rs1_reset = in_annot.first_retire && (rec.rs1_addr != 5'd0) &&
                       (rec.rs1_rdata != 32'd0);
    viol_d.rs2_reset = in_annot.first_retire && (rec.rs2_addr != 5'd0) &&
                       (rec.rs2_rdata != 32'd0);

    // Entry into debug mode from outside
    viol_d.dbg_cause = (rec.dbg != '0) && !in_annot.was_dbg_mode &&
                       (rec.dbg != dcsr_cause);

    // mcause is not written for exceptions taken in debug mode
    viol_d.exc_mismatch = rec.trap.exception && !rec.dbg_mode &&
                          (exc_cause_ext != mcause_exccode);

    viol_d.intr_illegal = rec.intr.interrupt && !cause_legal;

    viol_d.exc_no_cause = rec.trap.exception && (rec.trap.exception_cause == '0);
    viol_d.dbg_no_cause = rec.trap.debug && (rec.trap.debug_cause == '0);
  end

  trace_pipe_reg #(
    .T (trace_check_pkg::violation_t)
  ) u_pipe_reg (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .in_valid  (in_valid),
    .in_data   (viol_d),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_data  (out_viol),
    .out_ready (out_ready)
  );

endmodule

`default_nettype wire

// File: trace_violation_counter.sv
// Stage 3 of the trace checker: saturating failure count and report assembly

`timescale 1ns/100ps
`default_nettype none

module trace_violation_counter (
  input  logic                        clk_i,
  input  logic                        rst_ni,

  input  logic                        in_valid,
  input  trace_check_pkg::violation_t in_viol,
  output logic                        in_ready,

  output logic                        out_valid,
  output trace_check_pkg::report_t    out_report,
  input  logic                        out_ready
);

  logic [trace_check_pkg::CNT_W-1:0] count_q;
  logic [trace_check_pkg::CNT_W-1:0] count_d;
  logic                              any_fail;
  logic                              in_xfer;
  trace_check_pkg::report_t          report_d;

  assign in_xfer  = in_valid && in_ready;
  assign any_fail = |in_viol;

  // Sticks at the top value
  assign count_d = (any_fail && (count_q != '1)) ? count_q + 1'b1 : count_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q <= '0;
    end else if (in_xfer) begin
      count_q <= count_d;
    end
  end

  // Report holds the count including this record
  always_comb begin
    report_d            = '0;
    report_d.viol       = in_viol;
    report_d.any_fail   = any_fail;
    report_d.fail_count = count_d;
  end

  trace_pipe_reg #(
    .T (trace_check_pkg::report_t)
  ) u_pipe_reg (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .in_valid  (in_valid),
    .in_data   (report_d),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_data  (out_report),
    .out_ready (out_ready)
  );

endmodule

`default_nettype wire

// File: rvfi_trace_monitor.sv
// Top level of the retirement trace checker: mode tracker, cause checker and counter in a chain

`timescale 1ns/100ps
`default_nettype none

module rvfi_trace_monitor #(
  parameter logic CLIC          = 1'b0,
  parameter int   CLIC_ID_WIDTH = 5
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,

  input  logic                     in_valid,
  input  rvfi_trace_pkg::retire_t  in_rec,
  output logic                     in_ready,

  output logic                     out_valid,
  output trace_check_pkg::report_t out_report,
  input  logic                     out_ready
);

  // Stage 1 to stage 2
  logic                        s1_valid;
  logic                        s1_ready;
  rvfi_trace_pkg::annot_t      s1_annot;

  // Stage 2 to stage 3
  logic                        s2_valid;
  logic                        s2_ready;
  trace_check_pkg::violation_t s2_viol;

  trace_mode_tracker u_mode_tracker (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .in_valid  (in_valid),
    .in_rec    (in_rec),
    .in_ready  (in_ready),
    .out_valid (s1_valid),
    .out_annot (s1_annot),
    .out_ready (s1_ready)
  );

  trace_cause_checker #(
    .CLIC          (CLIC),
    .CLIC_ID_WIDTH (CLIC_ID_WIDTH)
  ) u_cause_checker (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .in_valid  (s1_valid),
    .in_annot  (s1_annot),
    .in_ready  (s1_ready),
    .out_valid (s2_valid),
    .out_viol  (s2_viol),
    .out_ready (s2_ready)
  );

  trace_violation_counter u_violation_counter (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .in_valid   (s2_valid),
    .in_viol    (s2_viol),
    .in_ready   (s2_ready),
    .out_valid  (out_valid),
    .out_report (out_report),
    .out_ready  (out_ready)
  );

endmodule

`default_nettype wire

// File: tb_rvfi_trace_monitor.sv
// Testbench for the retirement trace checker: record table, reference count and report checks

`timescale 1ns/100ps

module tb_rvfi_trace_monitor;

  localparam int NUM_ENTRIES     = 16;
  localparam int WATCHDOG_CYCLES = NUM_ENTRIES * 20 + 100;

  logic                        clk_i;
  logic                        rst_ni;
  logic                        in_valid;
  rvfi_trace_pkg::retire_t     in_rec;
  logic                        in_ready;
  logic                        out_valid;
  trace_check_pkg::report_t    out_report;
  logic                        out_ready;

  // Stimulus and expected masks, one row per record
  rvfi_trace_pkg::retire_t     rec_tab [NUM_ENTRIES];
  trace_check_pkg::violation_t exp_tab [NUM_ENTRIES];

  trace_check_pkg::report_t    rx_q [$];
  trace_check_pkg::report_t    held_report;
  logic                        hold_pending;
  integer                      seed;

  rvfi_trace_monitor #(
    .CLIC          (1'b0),
    .CLIC_ID_WIDTH (5)
  ) u_dut (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .in_valid   (in_valid),
    .in_rec     (in_rec),
    .in_ready   (in_ready),
    .out_valid  (out_valid),
    .out_report (out_report),
    .out_ready  (out_ready)
  );

  initial clk_i = 1'b0;

  always #20 clk_i = ~clk_i;

  task automatic check_equal(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
      $display("Finished with errors");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  task automatic set_intr(input int idx, input logic [10:0] cause, input logic illegal);
    rec_tab[idx].intr.interrupt  = 1'b1;
    rec_tab[idx].intr.cause      = cause;
    exp_tab[idx].intr_illegal    = illegal;
  endtask

  task automatic fill_table();
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      rec_tab[i] = '0;
      exp_tab[i] = '0;
    end
    // First retirement reads nonzero rs1 data with rs2 at address zero
    rec_tab[0].rs1_addr  = 5'd5;
    rec_tab[0].rs1_rdata = 32'hdead_beef;
    rec_tab[0].rs2_rdata = 32'h0000_1234;
    exp_tab[0].rs1_reset = 1'b1;
    rec_tab[1]           = rec_tab[0];
    // Debug entry with dcsr cause 1 but dbg 3
    rec_tab[2].dbg        = 3'd3;
    rec_tab[2].dcsr_rdata = 32'd1 << rvfi_trace_pkg::DCSR_CAUSE_LSB;
    rec_tab[2].dbg_mode   = 1'b1;
    exp_tab[2].dbg_cause  = 1'b1;
    // Same record while the previous one is in debug mode
    rec_tab[3] = rec_tab[2];
    // Masked mcause 5 against exception cause 2
    rec_tab[4].trap.exception       = 1'b1;
    rec_tab[4].trap.exception_cause = 6'd2;
    rec_tab[4].mcause_wdata         = 32'd5;
    rec_tab[4].mcause_wmask         = 32'hffff_ffff;
    exp_tab[4].exc_mismatch         = 1'b1;
    rec_tab[5]                      = rec_tab[4];
    rec_tab[5].dbg_mode             = 1'b1;
    // Mask strips the upper code bits down to 2
    rec_tab[6].trap.exception       = 1'b1;
    rec_tab[6].trap.exception_cause = 6'd2;
    rec_tab[6].mcause_wdata         = 32'h0000_07c2;
    rec_tab[6].mcause_wmask         = 32'h0000_003f;
    // Exception with zero cause
    rec_tab[7].trap.exception = 1'b1;
    exp_tab[7].exc_no_cause   = 1'b1;
    // Debug trap with zero cause
    rec_tab[8].trap.debug   = 1'b1;
    exp_tab[8].dbg_no_cause = 1'b1;
    // Debug entry that matches dcsr
    rec_tab[9].dbg              = 3'd2;
    rec_tab[9].dcsr_rdata       = (32'd2 << rvfi_trace_pkg::DCSR_CAUSE_LSB) | 32'h3;
    rec_tab[9].dbg_mode         = 1'b1;
    rec_tab[9].trap.debug       = 1'b1;
    rec_tab[9].trap.debug_cause = 3'd2;
    // Basic controller interrupt causes
    set_intr(10, 11'd11, 1'b0);
    set_intr(11, 11'd20, 1'b0);
    set_intr(12, 11'd1025, 1'b0);
    set_intr(13, 11'd0, 1'b1);
    set_intr(14, 11'd12, 1'b1);
    set_intr(15, 11'd40, 1'b1);
  endtask

  // Holds the record until the DUT takes it
  task automatic send_record(input int idx);
    logic accepted;
    accepted = 1'b0;
    in_valid <= 1'b1;
    in_rec   <= rec_tab[idx];
    while (!accepted) begin
      @(negedge clk_i);
      accepted = in_ready;
      @(posedge clk_i);
    end
  endtask

  // Reference count built from the table masks
  task automatic check_reports();
    trace_check_pkg::report_t          got;
    logic [trace_check_pkg::CNT_W-1:0] exp_count;
    logic                              exp_any;
    exp_count = '0;
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      got     = rx_q.pop_front();
      exp_any = |exp_tab[i];
      if (exp_any) begin
        exp_count = exp_count + 1'b1;
      end
      check_equal($sformatf("out_report.viol[%0d]", i), got.viol, exp_tab[i]);
      check_equal($sformatf("out_report.any_fail[%0d]", i), got.any_fail, exp_any);
      check_equal($sformatf("out_report.fail_count[%0d]", i), got.fail_count, exp_count);
    end
  endtask

  // About one cycle in four without ready
  always @(posedge clk_i) begin
    out_ready <= ($random(seed) & 32'h3) != 0;
  end

  // Sample between edges, where the handshake is stable
  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (hold_pending) begin
        check_equal("out_valid (stalled)", out_valid, 1'b1);
        check_equal("out_report (stalled)", out_report, held_report);
      end
      if (out_valid && out_ready) begin
        rx_q.push_back(out_report);
        hold_pending = 1'b0;
      end else if (out_valid) begin
        held_report  = out_report;
        hold_pending = 1'b1;
      end else begin
        hold_pending = 1'b0;
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("Timeout: reports stopped arriving after %0d of %0d", rx_q.size(), NUM_ENTRIES);
    $display("Finished with errors");
    $fatal(1, "Watchdog expired");
  end

  initial begin
    seed         = 28;
    rst_ni       = 1'b0;
    in_valid     = 1'b0;
    in_rec       = '0;
    out_ready    = 1'b0;
    hold_pending = 1'b0;
    fill_table();
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      send_record(i);
    end
    in_valid <= 1'b0;
    in_rec   <= '0;
    while (rx_q.size() < NUM_ENTRIES) begin
      @(posedge clk_i);
    end
    // Room for a duplicate report to show up
    repeat (10) @(posedge clk_i);
    check_equal("report count", rx_q.size(), NUM_ENTRIES);
    check_reports();
    $display("Finished with no errors");
    $finish;
  end

endmodule

// File: src.f
rvfi_trace_pkg.sv
trace_check_pkg.sv
trace_pipe_reg.sv
trace_mode_tracker.sv
trace_cause_checker.sv
trace_violation_counter.sv
rvfi_trace_monitor.sv
tb_rvfi_trace_monitor.sv

// File: Bender.yml
package:
  name: rvfi_trace_monitor

sources:
  - rvfi_trace_pkg.sv
  - trace_check_pkg.sv
  - trace_pipe_reg.sv
  - trace_mode_tracker.sv
  - trace_cause_checker.sv
  - trace_violation_counter.sv
  - rvfi_trace_monitor.sv
  - target: test
    files:
      - tb_rvfi_trace_monitor.sv
